// ==== Makefile ====
# Verilator simulation of the AHB-Lite I3C register block

VERILATOR ?= verilator
TOP       ?= tb_ahb_i3c_csr
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_ahb_i3c_csr.sv ====
////////////////////////////////////////////////////////////
// Directed testbench for the AHB-Lite I3C register block
// with AHB driver tasks and a shadow register model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_i3c_csr;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int NUM_REGS       = 6;

  typedef struct packed {
    logic            wr;
    logic [31:0]     addr;
    ahb_pkg::hsize_e size;
    logic [31:0]     data;  // Lane word
  } xfer_t;

  typedef struct packed {
    logic [63:0] rdata;
    logic        err;
    logic        order_ok;
    int          cycles;  // Address edge to completing edge
  } result_t;

  logic                   hclk;
  logic                   rst;
  ahb_pkg::ahb_req_t      ahb_req;
  ahb_pkg::ahb_rsp_t      ahb_rsp;
  i3c_csr_pkg::hwif_in_t  hwif_in;
  i3c_csr_pkg::hwif_out_t hwif_out;

  logic [31:0] shadow [NUM_REGS];
  xfer_t       xfer_q [$];
  result_t     result_q [$];
  int          n_checks;
  int          n_errors;

  ahb_i3c_csr_top UUT (
    .hclk_i    (hclk),
    .rst_i     (rst),
    .ahb_req_i (ahb_req),
    .ahb_rsp_o (ahb_rsp),
    .hwif_i    (hwif_in),
    .hwif_o    (hwif_out)
  );

  always #4 hclk = ~hclk;

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Writable bits per register index
  function automatic logic [31:0] write_mask(input int idx);
    case (idx)
      1:       return 32'h0000_0003;
      2:       return 32'h807F_0000;
      3:       return 32'h0000_003F;
      4:       return 32'h0000_00FF;
      5:       return 32'hFFFF_FFFF;
      default: return 32'h0000_0000;
    endcase
  endfunction

  // Active byte lanes of the 64-bit bus
  function automatic logic [7:0] lane_strobes(input logic [31:0] addr,
                                              input ahb_pkg::hsize_e size);
    int         nbytes;
    int         first;
    logic [7:0] strb;
    strb   = '0;
    nbytes = 1 << int'(size);
    first  = int'(addr[2:0]) & ~(nbytes - 1);
    for (int b = 0; b < 8; b++) begin
      if (b >= first && b < first + nbytes) strb[b] = 1'b1;
    end
    return strb;
  endfunction

  function automatic xfer_t make_xfer(input logic wr, input logic [31:0] addr,
                                      input ahb_pkg::hsize_e size, input logic [31:0] data);
    xfer_t x;
    x.wr   = wr;
    x.addr = addr;
    x.size = size;
    x.data = data;
    return x;
  endfunction

  function automatic void model_write(input xfer_t x);
    logic [7:0]  strb;
    logic [31:0] en;
    int          idx;
    strb = lane_strobes(x.addr, x.size);
    for (int b = 0; b < 4; b++) begin
      en[8*b +: 8] = {8{x.addr[2] ? strb[4 + b] : strb[b]}};
    end
    idx = int'(x.addr[7:2]);
    if (idx == 4)
      shadow[idx] &= ~(x.data & en & write_mask(idx));  // W1C
    else if (idx < NUM_REGS)
      shadow[idx] = (shadow[idx] & ~(en & write_mask(idx))) | (x.data & en & write_mask(idx));
  endfunction

  function automatic logic [63:0] expected_read(input logic [31:0] addr);
    int          idx;
    logic [31:0] w;
    idx = int'(addr[7:2]);
    w   = (idx < NUM_REGS) ? shadow[idx] : 32'h0;
    return addr[2] ? {w, 32'h0} : {32'h0, w};
  endfunction

  task automatic drive_addr(input xfer_t x);
    ahb_req.hsel   <= 1'b1;
    ahb_req.hready <= 1'b1;
    ahb_req.haddr  <= x.addr;
    ahb_req.htrans <= ahb_pkg::NONSEQ;
    ahb_req.hsize  <= x.size;
    ahb_req.hwrite <= x.wr;
    ahb_req.hwstrb <= x.wr ? lane_strobes(x.addr, x.size) : 8'h00;
  endtask

  // Runs xfer_q pipelined with the next address held over each data phase
  task automatic run_queue(input string name);
    result_t res;
    logic    done;
    logic    first_err;
    result_q.delete();
    if (xfer_q.size() > 0) drive_addr(xfer_q[0]);
    for (int i = 0; i < xfer_q.size(); i++) begin
      @(posedge hclk);
      ahb_req.hwdata <= xfer_q[i].addr[2] ? {xfer_q[i].data, ~xfer_q[i].data}
                                          : {~xfer_q[i].data, xfer_q[i].data};
      if (i + 1 < xfer_q.size()) begin
        drive_addr(xfer_q[i + 1]);
      end else begin
        ahb_req.hsel   <= 1'b0;
        ahb_req.htrans <= ahb_pkg::IDLE;
      end
      res       = '0;
      done      = 1'b0;
      first_err = 1'b0;
      while (!done && res.cycles < TIMEOUT_CYCLES) begin
        @(negedge hclk);
        res.cycles = res.cycles + 1;
        if (ahb_rsp.hresp && !ahb_rsp.hreadyout) first_err = 1'b1;
        if (ahb_rsp.hreadyout) begin
          done         = 1'b1;
          res.rdata    = ahb_rsp.hrdata;
          res.err      = ahb_rsp.hresp;
          res.order_ok = (ahb_rsp.hresp == first_err);
        end
      end
      if (!done) begin
        $display("Timeout: %s transfer %0d saw no hreadyout in %0d cycles",
                 name, i, TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
      end
      result_q.push_back(res);
    end
    @(posedge hclk);  // Completing edge of the last transfer
  endtask

  task automatic check_okay(input string name, input result_t res);
    check({name, " hresp"}, 64'd0, {63'h0, res.err});
    check({name, " cycles"}, 64'd2, 64'(res.cycles));
  endtask

  task automatic ahb_write(input string name, input logic [31:0] addr,
                           input ahb_pkg::hsize_e size, input logic [31:0] data);
    xfer_q.delete();
    xfer_q.push_back(make_xfer(1'b1, addr, size, data));
    run_queue(name);
    model_write(xfer_q[0]);
    check_okay(name, result_q[0]);
  endtask

  task automatic ahb_read(input string name, input logic [31:0] addr);
    xfer_q.delete();
    xfer_q.push_back(make_xfer(1'b0, addr, ahb_pkg::WORD, 32'h0));
    run_queue(name);
    check_okay(name, result_q[0]);
    check(name, expected_read(addr), result_q[0].rdata);
  endtask

  task automatic ahb_expect_error(input string name, input logic wr, input logic [31:0] addr,
                                  input ahb_pkg::hsize_e size);
    xfer_q.delete();
    xfer_q.push_back(make_xfer(wr, addr, size, 32'hFFFF_FFFF));
    run_queue(name);
    check({name, " hresp"}, 64'd1, {63'h0, result_q[0].err});
    check({name, " order"}, 64'd1, {63'h0, result_q[0].order_ok});
    check({name, " cycles"}, (size == ahb_pkg::DWORD) ? 64'd2 : 64'd3,
          64'(result_q[0].cycles));
  endtask

  task automatic check_all_regs(input string name);
    for (int k = 0; k < NUM_REGS; k++) begin
      ahb_read(name, 32'(4 * k));
    end
  endtask

  task automatic check_hwif(input string name);
    logic [15:0] exp;
    exp = {shadow[1][0], shadow[1][1], shadow[2][22:16], shadow[2][31], shadow[3][5:0]};
    @(negedge hclk);
    check(name, {48'h0, exp}, {48'h0, hwif_out});
    @(posedge hclk);
  endtask

  task automatic pulse_hwif(input i3c_csr_pkg::hwif_in_t value);
    hwif_in <= value;
    @(posedge hclk);
    hwif_in <= '0;
  endtask

  task automatic test_reset();
    check_hwif("reset hwif");
    ahb_req.hsel   <= 1'b1;  // IDLE transfer gets a zero-wait OKAY
    ahb_req.htrans <= ahb_pkg::IDLE;
    @(negedge hclk);
    check("reset hreadyout", 64'd1, {63'h0, ahb_rsp.hreadyout});
    check("reset hresp", 64'd0, {63'h0, ahb_rsp.hresp});
    @(posedge hclk);
    ahb_req.hsel <= 1'b0;
    check_all_regs("reset value");
  endtask

  task automatic test_word_rw();
    logic [31:0] alias_bits;
    for (int k = 1; k < NUM_REGS; k++) begin
      if (k != 4) begin
        alias_bits = $urandom() & 32'hFFFF_FF00;
        ahb_write("word write", alias_bits | 32'(4 * k), ahb_pkg::WORD, $urandom());
        ahb_read("word read", 32'(4 * k));
      end
    end
    check_hwif("word hwif");
    ahb_write("version write", 32'h00, ahb_pkg::WORD, $urandom());
    ahb_read("version read", 32'h00);
  endtask

  task automatic test_byte_lanes();
    ahb_write("scratch fill", 32'h14, ahb_pkg::WORD, 32'h0123_4567);
    for (int b = 0; b < 4; b++) begin
      ahb_write("scratch byte", 32'(32'h14 + b), ahb_pkg::BYTE, $urandom());
      ahb_read("scratch byte read", 32'h14);
    end
    ahb_write("scratch half lo", 32'h14, ahb_pkg::HALF, $urandom());
    ahb_read("scratch half lo read", 32'h14);
    ahb_write("scratch half hi", 32'h16, ahb_pkg::HALF, $urandom());
    ahb_read("scratch half hi read", 32'h14);
    ahb_write("control byte", 32'h04, ahb_pkg::BYTE, 32'h0000_0003);
    ahb_read("control upper lane", 32'h04);
    ahb_read("reset ctrl upper lane", 32'h0C);
  endtask

  task automatic test_errors();
    ahb_expect_error("unmapped read", 1'b0, 32'h18, ahb_pkg::WORD);
    ahb_expect_error("unmapped write", 1'b1, 32'h1C, ahb_pkg::WORD);
    ahb_expect_error("unmapped high write", 1'b1, 32'hF0, ahb_pkg::BYTE);
    ahb_expect_error("dword read", 1'b0, 32'h10, ahb_pkg::DWORD);
    ahb_expect_error("dword write", 1'b1, 32'h10, ahb_pkg::DWORD);
    check_all_regs("after errors");
  endtask

  task automatic test_hw_access();
    i3c_csr_pkg::hwif_in_t hw;
    hw          = '0;
    hw.intr_set = 8'h5A;
    pulse_hwif(hw);
    shadow[4] |= 32'h5A;
    ahb_read("intr set", 32'h10);
    ahb_write("intr clear", 32'h10, ahb_pkg::WORD, 32'h0000_0012);
    ahb_read("intr clear read", 32'h10);
    fork
      ahb_write("intr set wins", 32'h10, ahb_pkg::WORD, 32'h0000_00FF);
      begin
        @(posedge hclk);
        hwif_in.intr_set <= 8'h81;  // Lands in the strobe cycle
        @(posedge hclk);
        hwif_in.intr_set <= 8'h00;
      end
    join
    shadow[4] |= 32'h81;
    ahb_read("intr set wins read", 32'h10);
    hw                = '0;
    hw.dyn_addr_we    = 1'b1;
    hw.dyn_addr       = 7'h5A;
    hw.dyn_addr_valid = 1'b1;
    pulse_hwif(hw);
    shadow[2] = 32'h805A_0000;
    ahb_read("dyn addr load", 32'h08);
    ahb_write("reset ctrl fill", 32'h0C, ahb_pkg::WORD, 32'h0000_003F);
    hw             = '0;
    hw.reset_hwclr = 6'b01_0101;
    pulse_hwif(hw);
    shadow[3] &= ~32'h0000_0015;
    ahb_read("reset hwclr", 32'h0C);
    check_hwif("hw access hwif");
  endtask

  task automatic test_back_to_back();
    logic [31:0] r;
    xfer_q.delete();
    for (int k = 0; k < 24; k++) begin
      r = $urandom();
      xfer_q.push_back(make_xfer(r[0], 32'(4 + 4 * (int'(r[7:1]) % 5)), ahb_pkg::WORD,
                                 $urandom()));
    end
    run_queue("back to back");
    foreach (xfer_q[i]) begin
      if (xfer_q[i].wr) model_write(xfer_q[i]);
      else check("b2b read", expected_read(xfer_q[i].addr), result_q[i].rdata);
      check_okay("b2b", result_q[i]);
    end
    check_all_regs("after b2b");
    check_hwif("b2b hwif");
  endtask

  initial begin
    void'($urandom(32'h532b_6c7f));
    hclk     = 1'b0;
    rst      = 1'b1;
    ahb_req  = '0;
    hwif_in  = '0;
    n_checks = 0;
    n_errors = 0;
    shadow[0] = 32'h0000_0120;
    for (int k = 1; k < NUM_REGS; k++) begin
      shadow[k] = '0;
    end
    repeat (8) @(posedge hclk);
    rst <= 1'b0;
    test_reset();
    test_word_rw();
    test_byte_lanes();
    test_hw_access();
    test_errors();
    test_back_to_back();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/ahb_csr_bridge.sv ====
////////////////////////////////////////////////////////////
// AHB-Lite slave to CSR request bridge with byte lane
// selection and two-cycle error response
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ahb_csr_bridge (
  input  wire logic                    hclk_i,
  input  wire logic                    rst_i,
  input  wire ahb_pkg::ahb_req_t       ahb_req_i,
  output ahb_pkg::ahb_rsp_t            ahb_rsp_o,
  output i3c_csr_pkg::cpuif_req_t      cpuif_req_o,
  input  wire i3c_csr_pkg::cpuif_rsp_t cpuif_rsp_i
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    WAIT_ACK,
    ERROR  // Second error cycle
  } state_e;

  state_e state_q;
  state_e state_d;

  logic accept;
  logic size_ok;
  logic ack;
  logic ack_err;
  logic err_first;
  logic hreadyout;
  logic hresp;
  logic lane;

  logic                                      write_q;
  logic                                      size_err_q;
  logic [i3c_csr_pkg::CSR_ADDR_WIDTH-1:0]    addr_q;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0]    biten_q;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0]    biten_d;
  logic [ahb_pkg::AHB_DATA_WIDTH-1:0]        rdata_lane;

  assign accept = ahb_req_i.hsel && ahb_req_i.hready && hreadyout &&
                  (ahb_req_i.htrans == ahb_pkg::NONSEQ || ahb_req_i.htrans == ahb_pkg::SEQ);

  assign ack     = cpuif_rsp_i.rd_ack || cpuif_rsp_i.wr_ack;
  assign ack_err = (cpuif_rsp_i.rd_ack && cpuif_rsp_i.rd_err) ||
                   (cpuif_rsp_i.wr_ack && cpuif_rsp_i.wr_err);
  assign lane    = addr_q[2];  // Upper 32-bit lane

  // Byte enables from size and low address bits
  always_comb begin
    size_ok = 1'b1;
    biten_d = '0;
    case (ahb_req_i.hsize)
      ahb_pkg::BYTE: biten_d = 32'h0000_00FF << {ahb_req_i.haddr[1:0], 3'b000};
      ahb_pkg::HALF: biten_d = 32'h0000_FFFF << {ahb_req_i.haddr[1], 4'b0000};
      ahb_pkg::WORD: biten_d = '1;
      default:       size_ok = 1'b0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (accept) state_d = ACCESS;
      ACCESS:   state_d = size_err_q ? ERROR : WAIT_ACK;
      WAIT_ACK: begin
        if (ack_err) state_d = ERROR;
        else if (ack) state_d = accept ? ACCESS : IDLE;
      end
      ERROR:    state_d = accept ? ACCESS : IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge hclk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      write_q    <= 1'b0;
      size_err_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        write_q    <= ahb_req_i.hwrite;
        size_err_q <= !size_ok;
      end
    end
  end

  always_ff @(posedge hclk_i) begin
    if (accept) begin
      addr_q  <= ahb_req_i.haddr[i3c_csr_pkg::CSR_ADDR_WIDTH-1:0];  // Upper bits alias
      biten_q <= biten_d;
    end
  end

  assign err_first = (state_q == ACCESS && size_err_q) || (state_q == WAIT_ACK && ack_err);
  assign hreadyout = (state_q == IDLE) || (state_q == ERROR) ||
                     (state_q == WAIT_ACK && ack && !ack_err);
  assign hresp     = err_first || (state_q == ERROR);

  assign rdata_lane = lane ? {cpuif_rsp_i.rd_data, {i3c_csr_pkg::CSR_DATA_WIDTH{1'b0}}}
                           : {{i3c_csr_pkg::CSR_DATA_WIDTH{1'b0}}, cpuif_rsp_i.rd_data};

  always_comb begin
    ahb_rsp_o.hrdata    = rdata_lane;
    ahb_rsp_o.hreadyout = hreadyout;
    ahb_rsp_o.hresp     = hresp;
  end

  // hwdata is valid in the strobe cycle
  always_comb begin
    cpuif_req_o.req      = (state_q == ACCESS) && !size_err_q;
    cpuif_req_o.is_wr    = write_q;
    cpuif_req_o.addr     = addr_q;
    cpuif_req_o.wr_data  = lane ? ahb_req_i.hwdata[63:32] : ahb_req_i.hwdata[31:0];
    cpuif_req_o.wr_biten = biten_q;
  end

  // A strobe is followed by a wait without a second strobe
  assert property (@(posedge hclk_i) disable iff (rst_i)
    cpuif_req_o.req |=> (state_q == WAIT_ACK) && !cpuif_req_o.req);

  // First error cycle holds hreadyout low, then ERROR completes
  assert property (@(posedge hclk_i) disable iff (rst_i)
    err_first |=> hresp && hreadyout && $past(!hreadyout));

endmodule

`default_nettype wire

// ==== hdl/ahb_i3c_csr_top.sv ====
////////////////////////////////////////////////////////////
// AHB-Lite access to the I3C register block
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ahb_i3c_csr_top (
  input  wire logic                  hclk_i,
  input  wire logic                  rst_i,
  input  wire ahb_pkg::ahb_req_t     ahb_req_i,
  output ahb_pkg::ahb_rsp_t          ahb_rsp_o,
  input  wire i3c_csr_pkg::hwif_in_t hwif_i,
  output i3c_csr_pkg::hwif_out_t     hwif_o
);

  // CPU interface between bridge and registers
  i3c_csr_pkg::cpuif_req_t cpuif_req;
  i3c_csr_pkg::cpuif_rsp_t cpuif_rsp;

  ahb_csr_bridge u_bridge (
    .hclk_i      (hclk_i),
    .rst_i       (rst_i),
    .ahb_req_i   (ahb_req_i),
    .ahb_rsp_o   (ahb_rsp_o),
    .cpuif_req_o (cpuif_req),
    .cpuif_rsp_i (cpuif_rsp)
  );

  i3c_csr u_csr (
    .hclk_i      (hclk_i),
    .rst_i       (rst_i),
    .cpuif_req_i (cpuif_req),
    .cpuif_rsp_o (cpuif_rsp),
    .hwif_i      (hwif_i),   // Fields from the controller core
    .hwif_o      (hwif_o)
  );

endmodule

`default_nettype wire

// ==== hdl/ahb_pkg.sv ====
////////////////////////////////////////////////////////////
// AHB-Lite protocol widths, transfer type and size enums,
// request and response structs
////////////////////////////////////////////////////////////
`default_nettype none

package ahb_pkg;

  localparam int unsigned AHB_ADDR_WIDTH = 32;
  localparam int unsigned AHB_DATA_WIDTH = 64;
  localparam int unsigned AHB_STRB_WIDTH = AHB_DATA_WIDTH / 8;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HALF  = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011  // Wider than any CSR
  } hsize_e;

  typedef struct packed {
    logic                      hsel;
    logic                      hready;
    logic [AHB_ADDR_WIDTH-1:0] haddr;
    htrans_e                   htrans;
    hsize_e                    hsize;
    logic                      hwrite;
    logic [AHB_DATA_WIDTH-1:0] hwdata;
    logic [AHB_STRB_WIDTH-1:0] hwstrb;
  } ahb_req_t;

  typedef struct packed {
    logic [AHB_DATA_WIDTH-1:0] hrdata;
    logic                      hreadyout;
    logic                      hresp;  // High for ERROR
  } ahb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/i3c_csr.sv ====
////////////////////////////////////////////////////////////
// I3C control and status registers with software and
// hardware field access
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module i3c_csr (
  input  wire logic                    hclk_i,
  input  wire logic                    rst_i,
  input  wire i3c_csr_pkg::cpuif_req_t cpuif_req_i,
  output i3c_csr_pkg::cpuif_rsp_t      cpuif_rsp_o,
  input  wire i3c_csr_pkg::hwif_in_t   hwif_i,
  output i3c_csr_pkg::hwif_out_t       hwif_o
);

  logic                                     bus_enable_q;
  logic                                     resume_q;
  logic [i3c_csr_pkg::DYN_ADDR_WIDTH-1:0]   dyn_addr_q;
  logic                                     dyn_addr_valid_q;
  logic [i3c_csr_pkg::RESET_CTRL_WIDTH-1:0] reset_ctrl_q;
  logic [i3c_csr_pkg::INTR_WIDTH-1:0]       intr_status_q;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0]   scratch_q;

  logic [i3c_csr_pkg::CSR_ADDR_WIDTH-1:0]   word_addr;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0]   reg_word;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0]   wr_merged;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0]   wr_ones;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0]   rd_data_q;
  logic [i3c_csr_pkg::INTR_WIDTH-1:0]       intr_clr;
  logic                                     rd_stb;
  logic                                     wr_stb;
  logic                                     mapped;
  logic                                     rd_ack_q;
  logic                                     wr_ack_q;
  logic                                     err_q;

  assign word_addr = {cpuif_req_i.addr[i3c_csr_pkg::CSR_ADDR_WIDTH-1:2], 2'b00};
  assign rd_stb    = cpuif_req_i.req && !cpuif_req_i.is_wr;
  assign wr_stb    = cpuif_req_i.req && cpuif_req_i.is_wr;

  // Current value of the addressed register
  always_comb begin
    mapped   = 1'b1;
    reg_word = '0;
    case (word_addr)
      i3c_csr_pkg::HC_VERSION: reg_word = i3c_csr_pkg::HC_VERSION_VALUE;
      i3c_csr_pkg::HC_CONTROL: begin
        reg_word[i3c_csr_pkg::BUS_ENABLE_BIT] = bus_enable_q;
        reg_word[i3c_csr_pkg::RESUME_BIT]     = resume_q;
      end
      i3c_csr_pkg::CONTROLLER_DEVICE_ADDR: begin
        reg_word[i3c_csr_pkg::DYN_ADDR_LSB +: i3c_csr_pkg::DYN_ADDR_WIDTH] = dyn_addr_q;
        reg_word[i3c_csr_pkg::DYN_ADDR_VALID_BIT] = dyn_addr_valid_q;
      end
      i3c_csr_pkg::RESET_CONTROL: reg_word[i3c_csr_pkg::RESET_CTRL_WIDTH-1:0] = reset_ctrl_q;
      i3c_csr_pkg::INTR_STATUS:   reg_word[i3c_csr_pkg::INTR_WIDTH-1:0] = intr_status_q;
      i3c_csr_pkg::SCRATCH:       reg_word = scratch_q;
      default:                    mapped = 1'b0;
    endcase
  end

  assign wr_merged = (reg_word & ~cpuif_req_i.wr_biten) |
                     (cpuif_req_i.wr_data & cpuif_req_i.wr_biten);
  assign wr_ones   = cpuif_req_i.wr_data & cpuif_req_i.wr_biten;
  assign intr_clr  = (wr_stb && word_addr == i3c_csr_pkg::INTR_STATUS) ?
                     wr_ones[i3c_csr_pkg::INTR_WIDTH-1:0] : '0;

  always_ff @(posedge hclk_i) begin
    if (rst_i) begin
      bus_enable_q     <= 1'b0;
      resume_q         <= 1'b0;
      dyn_addr_q       <= '0;
      dyn_addr_valid_q <= 1'b0;
      reset_ctrl_q     <= '0;
      intr_status_q    <= '0;
      scratch_q        <= '0;
    end else begin
      if (wr_stb && word_addr == i3c_csr_pkg::HC_CONTROL) begin
        bus_enable_q <= wr_merged[i3c_csr_pkg::BUS_ENABLE_BIT];
        resume_q     <= wr_merged[i3c_csr_pkg::RESUME_BIT];
      end
      if (hwif_i.dyn_addr_we) begin  // Hardware load has priority
        dyn_addr_q       <= hwif_i.dyn_addr;
        dyn_addr_valid_q <= hwif_i.dyn_addr_valid;
      end else if (wr_stb && word_addr == i3c_csr_pkg::CONTROLLER_DEVICE_ADDR) begin
        dyn_addr_q       <= wr_merged[i3c_csr_pkg::DYN_ADDR_LSB +: i3c_csr_pkg::DYN_ADDR_WIDTH];
        dyn_addr_valid_q <= wr_merged[i3c_csr_pkg::DYN_ADDR_VALID_BIT];
      end
      if (wr_stb && word_addr == i3c_csr_pkg::RESET_CONTROL)
        reset_ctrl_q <= wr_merged[i3c_csr_pkg::RESET_CTRL_WIDTH-1:0] & ~hwif_i.reset_hwclr;
      else
        reset_ctrl_q <= reset_ctrl_q & ~hwif_i.reset_hwclr;
      intr_status_q <= (intr_status_q & ~intr_clr) | hwif_i.intr_set;  // Set wins
      if (wr_stb && word_addr == i3c_csr_pkg::SCRATCH) scratch_q <= wr_merged;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (rst_i) begin
      rd_ack_q <= 1'b0;
      wr_ack_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rd_ack_q <= rd_stb;
      wr_ack_q <= wr_stb;
      err_q    <= cpuif_req_i.req && !mapped;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (rd_stb) rd_data_q <= reg_word;  // Value before a same-cycle write
  end

  always_comb begin
    cpuif_rsp_o.rd_ack  = rd_ack_q;
    cpuif_rsp_o.rd_err  = rd_ack_q && err_q;
    cpuif_rsp_o.rd_data = rd_data_q;
    cpuif_rsp_o.wr_ack  = wr_ack_q;
    cpuif_rsp_o.wr_err  = wr_ack_q && err_q;
  end

  always_comb begin
    hwif_o.bus_enable     = bus_enable_q;
    hwif_o.resume         = resume_q;
    hwif_o.dyn_addr       = dyn_addr_q;
    hwif_o.dyn_addr_valid = dyn_addr_valid_q;
    hwif_o.reset_ctrl     = reset_ctrl_q;
  end

  assert property (@(posedge hclk_i) disable iff (rst_i)
    !(cpuif_rsp_o.rd_ack && cpuif_rsp_o.wr_ack));

  // Acks only answer the previous cycle's strobe
  assert property (@(posedge hclk_i) disable iff (rst_i)
    (cpuif_rsp_o.rd_ack || cpuif_rsp_o.wr_ack) |-> $past(cpuif_req_i.req));

endmodule

`default_nettype wire

// ==== hdl/i3c_csr_pkg.sv ====
////////////////////////////////////////////////////////////
// I3C register map, CPU interface structs and
// hardware field structs
////////////////////////////////////////////////////////////
`default_nettype none

package i3c_csr_pkg;

  localparam int unsigned CSR_DATA_WIDTH = 32;
  localparam int unsigned CSR_ADDR_WIDTH = 8;

  // Field positions and widths
  localparam int unsigned BUS_ENABLE_BIT     = 0;
  localparam int unsigned RESUME_BIT         = 1;
  localparam int unsigned DYN_ADDR_LSB       = 16;
  localparam int unsigned DYN_ADDR_WIDTH     = 7;
  localparam int unsigned DYN_ADDR_VALID_BIT = 31;
  localparam int unsigned RESET_CTRL_WIDTH   = 6;
  localparam int unsigned INTR_WIDTH         = 8;

  localparam logic [CSR_DATA_WIDTH-1:0] HC_VERSION_VALUE = 32'h0000_0120;

  typedef enum logic [CSR_ADDR_WIDTH-1:0] {
    HC_VERSION             = 8'h00,
    HC_CONTROL             = 8'h04,
    CONTROLLER_DEVICE_ADDR = 8'h08,
    RESET_CONTROL          = 8'h0C,
    INTR_STATUS            = 8'h10,  // W1C
    SCRATCH                = 8'h14
  } csr_reg_e;

  typedef struct packed {
    logic                      req;
    logic                      is_wr;
    logic [CSR_ADDR_WIDTH-1:0] addr;
    logic [CSR_DATA_WIDTH-1:0] wr_data;
    logic [CSR_DATA_WIDTH-1:0] wr_biten;
  } cpuif_req_t;

  typedef struct packed {
    logic                      rd_ack;
    logic                      rd_err;
    logic [CSR_DATA_WIDTH-1:0] rd_data;
    logic                      wr_ack;
    logic                      wr_err;
  } cpuif_rsp_t;

  typedef struct packed {
    logic                        dyn_addr_we;
    logic [DYN_ADDR_WIDTH-1:0]   dyn_addr;
    logic                        dyn_addr_valid;
    logic [RESET_CTRL_WIDTH-1:0] reset_hwclr;
    logic [INTR_WIDTH-1:0]       intr_set;  // Pulses
  } hwif_in_t;

  typedef struct packed {
    logic                        bus_enable;
    logic                        resume;
    logic [DYN_ADDR_WIDTH-1:0]   dyn_addr;
    logic                        dyn_addr_valid;
    logic [RESET_CTRL_WIDTH-1:0] reset_ctrl;
  } hwif_out_t;

endpackage

`default_nettype wire

// ==== project.f ====
hdl/ahb_pkg.sv
hdl/i3c_csr_pkg.sv
hdl/ahb_csr_bridge.sv
hdl/i3c_csr.sv
hdl/ahb_i3c_csr_top.sv
bench/tb_ahb_i3c_csr.sv
